// ==== bench/tb_clock.sv ====
// Testbench clock source
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS = 40
) (
   output logic clk
);

   // Free running, starts low
   initial clk = 1'b0;
   always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== bench/tb_top.sv ====
// Memory subsystem testbench
`timescale 1ns/1ps

module tb_top;
   import mem_pkg::*;

   localparam int ADDR_WIDTH  = 8;
   localparam int QUEUE_DEPTH = 4;
   localparam int WAIT_LIMIT  = 200;
   localparam int DRIVE_DELAY = 5;

   logic                  clk;
   logic                  rst;
   logic                  req;
   cmd_op_e               op;
   logic [ADDR_WIDTH-1:0] addr;
   logic [DATA_W-1:0]     wdata;
   logic                  ack;
   logic                  rd_valid;
   logic [DATA_W-1:0]     rd_data;
   logic [ADDR_WIDTH-1:0] rd_addr;
   logic                  busy;

   // Reference model, keyed by byte address
   logic [DATA_W-1:0]     model [logic [ADDR_WIDTH-1:0]];
   // Accepted reads, oldest first
   logic [ADDR_WIDTH-1:0] exp_addr_q [$];
   logic [DATA_W-1:0]     exp_data_q [$];
   logic [ADDR_WIDTH-1:0] used_addr [$];
   // Expectation for the result sampled at the next edge
   logic [ADDR_WIDTH-1:0] exp_addr;
   logic [DATA_W-1:0]     exp_data;
   logic                  exp_valid;
   logic                  idle_check;
   logic [31:0]           lcg_state;
   string                 test_name;
   int                    err_count;
   int                    errs_at_start;
   int                    tests_run;
   int                    tests_failed;
   int                    reads_sent;
   int                    results_seen;

   tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

   mem_subsys_top #(.ADDR_WIDTH(ADDR_WIDTH), .QUEUE_DEPTH(QUEUE_DEPTH)) dut (
      .clk(clk), .rst(rst), .req(req), .op(op), .addr(addr), .wdata(wdata),
      .ack(ack), .rd_valid(rd_valid), .rd_data(rd_data), .rd_addr(rd_addr), .busy(busy)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Checkers
   ////////////////////////////////////////////////////////////////////////////

   a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
      idle_check |-> (!ack && !rd_valid && !busy))
      else begin
         err_count++;
         $display("%s: ack, rd_valid or busy high while the DUT is idle", test_name);
      end

   a_read_data: assert property (@(posedge clk) disable iff (rst)
      (rd_valid && exp_valid) |-> (rd_data == exp_data))
      else begin
         err_count++;
         $display("[ERROR] %s: rd_data expected %h actual %h",
                  test_name, exp_data, $sampled(rd_data));
      end

   // Results in acceptance order
   a_read_order: assert property (@(posedge clk) disable iff (rst)
      (rd_valid && exp_valid) |-> (rd_addr == exp_addr))
      else begin
         err_count++;
         $display("[ERROR] %s: rd_addr expected %h actual %h",
                  test_name, exp_addr, $sampled(rd_addr));
      end

   a_result_expected: assert property (@(posedge clk) disable iff (rst)
      rd_valid |-> exp_valid)
      else begin
         err_count++;
         $display("%s: read result arrived with no read outstanding", test_name);
      end

   // Four-phase rules at the host port
   a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      (!req && !ack) |=> !ack)
      else begin
         err_count++;
         $display("%s: ack rose while req was low", test_name);
      end

   a_ack_holds: assert property (@(posedge clk) disable iff (rst)
      (ack && req) |=> ack)
      else begin
         err_count++;
         $display("%s: ack dropped while req was still high", test_name);
      end

   a_ack_drops: assert property (@(posedge clk) disable iff (rst)
      (ack && !req) |=> !ack)
      else begin
         err_count++;
         $display("%s: ack stayed high after req fell", test_name);
      end

   // Load the expectation for the pulse sampled at the coming edge
   always @(negedge clk) begin
      if (!rst && rd_valid) begin
         results_seen++;
         exp_valid = (exp_addr_q.size() != 0);
         if (exp_valid) begin
            exp_addr = exp_addr_q.pop_front();
            exp_data = exp_data_q.pop_front();
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [ADDR_WIDTH-1:0] rand_even_addr();
      logic [31:0] r;
      r = next_random();
      return {r[ADDR_WIDTH+14:16], 1'b0};
   endfunction

   function automatic logic [DATA_W-1:0] rand_word();
      logic [31:0] r;
      r = next_random();
      return r[31:16];
   endfunction

   // One full req/ack cycle, req held hold extra cycles after ack
   task automatic host_command(input cmd_op_e c_op, input logic [ADDR_WIDTH-1:0] c_addr,
                               input logic [DATA_W-1:0] c_data, input int hold);
      int waited;
      op     = c_op;
      addr   = c_addr;
      wdata  = c_data;
      req    = 1'b1;
      waited = 0;
      do begin
         @(posedge clk);
         #DRIVE_DELAY;
         waited++;
      end while (!ack && waited < WAIT_LIMIT);
      if (!ack) begin
         err_count++;
         $display("%s: no ack for command at address %h", test_name, c_addr);
      end else if (c_op == OP_WRITE) begin
         model[c_addr] = c_data;
      end else begin
         exp_addr_q.push_back(c_addr);
         exp_data_q.push_back(model[c_addr]);
         reads_sent++;
      end
      repeat (hold) begin
         @(posedge clk);
         #DRIVE_DELAY;
      end
      req    = 1'b0;
      waited = 0;
      do begin
         @(posedge clk);
         #DRIVE_DELAY;
         waited++;
      end while (ack && waited < WAIT_LIMIT);
      if (ack) begin
         err_count++;
         $display("%s: ack never fell after req dropped", test_name);
      end
   endtask

   // Until every read has returned and the DUT is quiet
   task automatic wait_drained();
      int waited;
      waited = 0;
      do begin
         @(posedge clk);
         #DRIVE_DELAY;
         waited++;
      end while ((busy || rd_valid || exp_addr_q.size() != 0) && waited < WAIT_LIMIT);
      if (busy || exp_addr_q.size() != 0) begin
         err_count++;
         $display("%s: DUT did not drain, %0d reads outstanding", test_name, exp_addr_q.size());
      end
      a_result_count: assert (results_seen == reads_sent) else begin
         err_count++;
         $display("[ERROR] %s: result count expected %0d actual %0d",
                  test_name, reads_sent, results_seen);
      end
   endtask

   task automatic check_idle(input int cycles);
      idle_check = 1'b1;
      repeat (cycles) begin
         @(posedge clk);
         #DRIVE_DELAY;
      end
      idle_check = 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name     = name;
      errs_at_start = err_count;
   endtask

   task automatic finish_test();
      tests_run++;
      if (err_count != errs_at_start) begin
         tests_failed++;
      end
      $display("test %s: %s, %0d errors", test_name,
               (err_count == errs_at_start) ? "passed" : "failed", err_count - errs_at_start);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      logic [ADDR_WIDTH-1:0] a;
      logic [ADDR_WIDTH-1:0] order_addr [4];
      rst          = 1'b1;
      req          = 1'b0;
      op           = OP_READ;
      addr         = '0;
      wdata        = '0;
      idle_check   = 1'b0;
      exp_valid    = 1'b0;
      exp_addr     = '0;
      exp_data     = '0;
      lcg_state    = 32'd34700;
      test_name    = "reset";
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      reads_sent   = 0;
      results_seen = 0;
      repeat (16) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;

      start_test("reset_idle");
      check_idle(4);
      finish_test();

      // Each write read straight back
      start_test("write_read");
      for (int i = 0; i < 6; i++) begin
         a = rand_even_addr();
         host_command(OP_WRITE, a, rand_word(), 0);
         host_command(OP_READ, a, '0, 0);
         used_addr.push_back(a);
      end
      wait_drained();
      finish_test();

      // Back to back reads, some with req held past ack
      start_test("handshake");
      foreach (used_addr[i]) begin
         host_command(OP_READ, used_addr[i], '0, i % 3);
      end
      wait_drained();
      finish_test();

      // Reverse order reads expose any reordering
      start_test("ordering");
      foreach (order_addr[i]) begin
         order_addr[i] = rand_even_addr();
         host_command(OP_WRITE, order_addr[i], rand_word(), 0);
      end
      for (int i = 3; i >= 0; i--) begin
         host_command(OP_READ, order_addr[i], '0, 0);
      end
      host_command(OP_READ, order_addr[3], '0, 0);
      wait_drained();
      finish_test();

      // Write burst then read burst, no gaps
      start_test("burst");
      for (int i = 0; i < 8; i++) begin
         a = rand_even_addr();
         host_command(OP_WRITE, a, rand_word(), 0);
         used_addr.push_back(a);
      end
      for (int i = 0; i < 8; i++) begin
         host_command(OP_READ, used_addr[used_addr.size() - 1 - i], '0, 0);
      end
      wait_drained();
      check_idle(4);
      finish_test();

      $display("tests run %0d, failed %0d, errors %0d, reads %0d, results %0d",
               tests_run, tests_failed, err_count, reads_sent, results_seen);
      if (err_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== build.f ====
logic/mem_pkg.sv
logic/mem_cmd_if.sv
logic/host_req_port.sv
logic/cmd_queue.sv
logic/mem_sequencer.sv
logic/pipelined_mem.sv
logic/mem_subsys_top.sv
bench/tb_clock.sv
bench/tb_top.sv

// ==== logic/cmd_queue.sv ====
// Command FIFO
`timescale 1ns/1ps

module cmd_queue #(
   parameter int ADDR_WIDTH  = 8,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic   clk,
   input  logic   rst,
   mem_cmd_if.dst wr,
   mem_cmd_if.src rd
);
   import mem_pkg::*;

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   // Entry storage, one array per field
   cmd_op_e               op_mem   [QUEUE_DEPTH];
   logic [ADDR_WIDTH-1:0] addr_mem [QUEUE_DEPTH];
   logic [DATA_W-1:0]     data_mem [QUEUE_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   assign wr.ready = (count != CNT_W'(QUEUE_DEPTH));
   assign rd.valid = (count != '0);
   assign push     = wr.valid && wr.ready;
   assign pop      = rd.valid && rd.ready;

   // Head entry
   assign rd.op    = op_mem[rd_ptr];
   assign rd.addr  = addr_mem[rd_ptr];
   assign rd.wdata = data_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         op_mem[wr_ptr]   <= wr.op;
         addr_mem[wr_ptr] <= wr.addr;
         data_mem[wr_ptr] <= wr.wdata;
      end
   end

   // Pointers wrap at depth, so any depth works
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop) rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         // Simultaneous push and pop leaves count alone
         if (push && !pop) count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

   // Count tracks the distance between the pointers
   a_ptr_count_agree: assert property (
      @(posedge clk) disable iff (rst)
         int'(wr_ptr) == (int'(rd_ptr) + int'(count)) % QUEUE_DEPTH
   ) else $error("cmd_queue: count disagrees with pointers");

   // Push into an empty queue shows at the head next cycle
   a_push_to_head: assert property (
      @(posedge clk) disable iff (rst)
         (push && count == '0) |=> (rd.valid && rd.op == $past(wr.op) &&
                                    rd.addr == $past(wr.addr) &&
                                    rd.wdata == $past(wr.wdata))
   ) else $error("cmd_queue: pushed command missing from head");

endmodule

// ==== logic/host_req_port.sv ====
// Four-phase host request port
`timescale 1ns/1ps

module host_req_port #(
   parameter int ADDR_WIDTH = 8
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      req,
   input  mem_pkg::cmd_op_e          op,
   input  logic [ADDR_WIDTH-1:0]     addr,
   input  logic [mem_pkg::DATA_W-1:0] wdata,
   output logic                      ack,
   mem_cmd_if.src                    push
);
   import mem_pkg::*;

   port_state_e state;
   logic        push_done;

   ////////////////////////////////////////////////////////////////////////////
   // Command offer toward the queue
   ////////////////////////////////////////////////////////////////////////////

   // Host holds fields stable while req is high
   assign push.op    = op;
   assign push.addr  = addr;
   assign push.wdata = wdata;

   // Offer only once per req, before ack
   assign push.valid = (state == PORT_IDLE) && req;
   assign push_done  = push.valid && push.ready;

   ////////////////////////////////////////////////////////////////////////////
   // Handshake FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= PORT_IDLE;
      end else begin
         case (state)
            // Full queue keeps us here, ack stays low
            PORT_IDLE: if (push_done) state <= PORT_ACK;
            // Host may already have dropped req
            PORT_ACK: state <= req ? PORT_WAIT_DROP : PORT_IDLE;
            PORT_WAIT_DROP: if (!req) state <= PORT_IDLE;
            default: state <= PORT_IDLE;
         endcase
      end
   end

   // Ack high from the cycle after the push until req is seen low
   assign ack = (state != PORT_IDLE);

   // A new req only once the previous ack has dropped
   a_no_req_during_ack: assert property (
      @(posedge clk) disable iff (rst) $rose(req) |-> !ack
   ) else $error("host_req_port: req raised while ack high");

endmodule

// ==== logic/mem_cmd_if.sv ====
// Memory command channel
`timescale 1ns/1ps

interface mem_cmd_if #(
   parameter int ADDR_WIDTH = 8
);
   import mem_pkg::*;

   // Command fields, held stable while valid is high
   cmd_op_e               op;
   logic [ADDR_WIDTH-1:0] addr;
   logic [DATA_W-1:0]     wdata;

   // Transfer on an edge where both are high
   logic                  valid;
   logic                  ready;

   // Sender side
   modport src (output op, addr, wdata, valid, input ready);

   // Receiver side
   modport dst (input op, addr, wdata, valid, output ready);

endinterface

// ==== logic/mem_pkg.sv ====
// Memory subsystem shared definitions
package mem_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Data path sizing
   ////////////////////////////////////////////////////////////////////////////

   // Width of one memory word
   localparam int DATA_W = 16;

   // Cycles from read issue to result
   localparam int READ_LATENCY = 4;

   ////////////////////////////////////////////////////////////////////////////
   // Enumerations
   ////////////////////////////////////////////////////////////////////////////

   // Command opcode
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } cmd_op_e;

   // Host port handshake states
   typedef enum logic [1:0] {
      PORT_IDLE,
      PORT_ACK,
      PORT_WAIT_DROP
   } port_state_e;

endpackage

// ==== logic/mem_sequencer.sv ====
// Memory command sequencer
`timescale 1ns/1ps

module mem_sequencer #(
   parameter int ADDR_WIDTH = 8
) (
   input  logic                       clk,
   input  logic                       rst,
   mem_cmd_if.dst                     cmd,
   // Memory side
   output logic                       mem_enable,
   output logic                       mem_wr,
   output logic [ADDR_WIDTH-1:0]      mem_addr,
   output logic [mem_pkg::DATA_W-1:0] mem_wdata,
   input  logic [mem_pkg::DATA_W-1:0] mem_rdata,
   input  logic                       mem_rvalid,
   // Tagged read results
   output logic                       rd_valid,
   output logic [mem_pkg::DATA_W-1:0] rd_data,
   output logic [ADDR_WIDTH-1:0]      rd_addr,
   output logic                       busy
);
   import mem_pkg::*;

   localparam int CNT_W = $clog2(READ_LATENCY + 1);

   logic                  issue;
   logic                  issue_read;
   logic [CNT_W-1:0]      inflight;
   // Address tags, aligned with the memory read stages
   logic [ADDR_WIDTH-1:0] tag_pipe [READ_LATENCY];

   ////////////////////////////////////////////////////////////////////////////
   // Issue
   ////////////////////////////////////////////////////////////////////////////

   // Memory accepts one access every cycle
   assign cmd.ready  = 1'b1;
   assign issue      = cmd.valid && cmd.ready;
   assign issue_read = issue && (cmd.op == OP_READ);

   // Queue head goes straight to the memory port
   assign mem_enable = issue;
   assign mem_wr     = issue && (cmd.op == OP_WRITE);
   assign mem_addr   = cmd.addr;
   assign mem_wdata  = cmd.wdata;

   ////////////////////////////////////////////////////////////////////////////
   // Result tagging
   ////////////////////////////////////////////////////////////////////////////

   // Shift every cycle, same cadence as the data stages
   always_ff @(posedge clk) begin
      tag_pipe[0] <= cmd.addr;
      for (int i = 1; i < READ_LATENCY; i++) begin
         tag_pipe[i] <= tag_pipe[i-1];
      end
   end

   // Reads between issue and result
   always_ff @(posedge clk) begin
      if (rst) begin
         inflight <= '0;
      end else if (issue_read && !mem_rvalid) begin
         inflight <= inflight + 1'b1;
      end else if (mem_rvalid && !issue_read) begin
         inflight <= inflight - 1'b1;
      end
   end

   assign rd_valid = mem_rvalid;
   assign rd_data  = mem_rdata;
   assign rd_addr  = tag_pipe[READ_LATENCY-1];

   // Queued command or read still in the pipe
   assign busy = (inflight != '0) || cmd.valid;

   a_rvalid_has_read: assert property (
      @(posedge clk) disable iff (rst) mem_rvalid |-> (inflight != '0)
   ) else $error("mem_sequencer: read result with nothing in flight");

endmodule

// ==== logic/mem_subsys_top.sv ====
// Memory subsystem top level
`timescale 1ns/1ps

module mem_subsys_top #(
   parameter int ADDR_WIDTH  = 8,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                       clk,
   input  logic                       rst,
   // Host command, four-phase req/ack
   input  logic                       req,
   input  mem_pkg::cmd_op_e           op,
   input  logic [ADDR_WIDTH-1:0]      addr,
   input  logic [mem_pkg::DATA_W-1:0] wdata,
   output logic                       ack,
   // Read results, one-cycle pulse
   output logic                       rd_valid,
   output logic [mem_pkg::DATA_W-1:0] rd_data,
   output logic [ADDR_WIDTH-1:0]      rd_addr,
   output logic                       busy
);
   import mem_pkg::*;

   logic                  mem_enable;
   logic                  mem_wr;
   logic [ADDR_WIDTH-1:0] mem_addr;
   logic [DATA_W-1:0]     mem_wdata;
   logic [DATA_W-1:0]     mem_rdata;
   logic                  mem_rvalid;

   // Port to queue, queue to sequencer
   mem_cmd_if #(.ADDR_WIDTH(ADDR_WIDTH)) push_if ();
   mem_cmd_if #(.ADDR_WIDTH(ADDR_WIDTH)) pop_if ();

   host_req_port #(.ADDR_WIDTH(ADDR_WIDTH)) u_port (
      .clk(clk), .rst(rst), .req(req), .op(op), .addr(addr), .wdata(wdata),
      .ack(ack), .push(push_if)
   );

   cmd_queue #(.ADDR_WIDTH(ADDR_WIDTH), .QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
      .clk(clk), .rst(rst), .wr(push_if), .rd(pop_if)
   );

   mem_sequencer #(.ADDR_WIDTH(ADDR_WIDTH)) u_seq (
      .clk(clk), .rst(rst), .cmd(pop_if),
      .mem_enable(mem_enable), .mem_wr(mem_wr), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid),
      .rd_valid(rd_valid), .rd_data(rd_data), .rd_addr(rd_addr), .busy(busy)
   );

   pipelined_mem #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem (
      .clk(clk), .rst(rst), .enable(mem_enable), .wr(mem_wr), .addr(mem_addr),
      .data_in(mem_wdata), .data_out(mem_rdata), .data_valid(mem_rvalid)
   );

endmodule

// ==== logic/pipelined_mem.sv ====
// Pipelined word memory
`timescale 1ns/1ps

module pipelined_mem #(
   parameter int ADDR_WIDTH = 8
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable,
   input  logic                       wr,
   input  logic [ADDR_WIDTH-1:0]      addr,
   input  logic [mem_pkg::DATA_W-1:0] data_in,
   output logic [mem_pkg::DATA_W-1:0] data_out,
   output logic                       data_valid
);
   import mem_pkg::*;

   // Byte addressed, so one word per even address
   logic [DATA_W-1:0] mem [2**(ADDR_WIDTH-1)];

   logic              rd_en;
   logic [DATA_W-1:0] rd_word;
   logic [DATA_W-1:0] data_stage  [READ_LATENCY];
   logic              valid_stage [READ_LATENCY];

   assign rd_en   = enable && !wr;
   assign rd_word = rd_en ? mem[addr[ADDR_WIDTH-1:1]] : '0;

   // Write lands at this edge, visible to a read next cycle
   always_ff @(posedge clk) begin
      if (enable && wr) begin
         mem[addr[ADDR_WIDTH-1:1]] <= data_in;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read stages
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < READ_LATENCY; i++) begin
            data_stage[i]  <= '0;
            valid_stage[i] <= 1'b0;
         end
      end else begin
         data_stage[0]  <= rd_word;
         valid_stage[0] <= rd_en;
         for (int i = 1; i < READ_LATENCY; i++) begin
            data_stage[i]  <= data_stage[i-1];
            valid_stage[i] <= valid_stage[i-1];
         end
      end
   end

   assign data_out   = data_stage[READ_LATENCY-1];
   assign data_valid = valid_stage[READ_LATENCY-1];

   a_addr_aligned: assert property (
      @(posedge clk) disable iff (rst) enable |-> !addr[0]
   ) else $error("pipelined_mem: odd address on access");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
   -f build.f --Mdir obj_dir -o tb_top_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_top_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Simulation finished: PASS" "$SIM_LOG"; then
   exit 0
fi
exit 1
